// File: design/smc_pkg.sv
/*
  Shared types and widths for the static memory controller.
  State encoding is one-hot, five states.
  Timing fields are counted in sys_clk4 cycles.
*/
package smc_pkg;

  localparam int SMC_ADDR_W = 32;  // Host address width
  localparam int SMC_DATA_W = 32;  // Host data width

  // ------------------------------
  // Access state machine
  // ------------------------------
  typedef enum logic [4:0] {
    st_idle  = 5'b00001,  // No access
    st_store = 5'b00010,  // Timing values loaded
    st_le    = 5'b00100,  // Chip select leading edge
    st_rw    = 5'b01000,  // Strobe active, wait states
    st_float = 5'b10000   // Chip select trailing edge
  } smc_state_e;

  // Host access size
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } smc_size_e;

  // ------------------------------
  // Timing set, 14 bits
  // ------------------------------
  typedef struct packed {
    logic [1:0] csle;  // Leading edge cycles
    logic [7:0] ws;    // Wait states
    logic [1:0] oete;  // Output enable rise before end of rw
    logic [1:0] cste;  // Float cycles
  } smc_cfg_t;

endpackage

// File: design/smc_beat_if.sv
/*
  Per-beat control between FSM, counters, beat controller and pins.
  mem_rdata enters as an interface port from the top level.
*/
interface smc_beat_if #(parameter int MEM_WIDTH = 8) (
  input logic [MEM_WIDTH-1:0] mem_rdata  // Raw memory read data
);
  import smc_pkg::*;

  smc_state_e                cur_state;     // Registered state
  smc_state_e                next_state;    // Combinational next state
  logic                      le_enable;     // Leading edge count down
  logic                      ws_enable;     // Wait count reload
  logic                      cste_enable;   // Float count down
  logic                      latch_data;    // Read data window
  logic                      valid_access;  // New access accepted
  logic                      beat_done;     // Last cycle of a beat
  logic [1:0]                r_csle_count;
  logic [7:0]                r_ws_count;
  logic [1:0]                r_cste_count;
  logic [1:0]                csle_store;
  logic [1:0]                oete_store;
  logic                      new_access;    // Host request this cycle
  logic                      mac_done;      // Current beat is the last
  logic                      rw_change;     // Direction or bank change
  logic [SMC_ADDR_W-1:0]     beat_addr;     // Address for next cycle
  logic [MEM_WIDTH-1:0]      beat_wdata;    // Write slice for next cycle
  logic                      beat_write;    // Direction for next cycle

  modport fsm (
    output cur_state, next_state, le_enable, ws_enable, cste_enable,
           latch_data, valid_access, beat_done,
    input  r_csle_count, r_ws_count, r_cste_count, csle_store, oete_store,
           new_access, mac_done, rw_change
  );

  modport cnt (
    output r_csle_count, r_ws_count, r_cste_count, csle_store, oete_store,
    input  valid_access, le_enable, ws_enable, cste_enable, beat_done
  );

  modport mac (
    output new_access, mac_done, rw_change, beat_addr, beat_wdata, beat_write,
    input  valid_access, beat_done, latch_data, mem_rdata
  );

  modport pins (
    input cur_state, next_state, latch_data, beat_done,
          beat_addr, beat_wdata, beat_write
  );

endinterface

// File: design/smc_state.sv
/*
  Access FSM. Back-to-back requests skip idle and keep chip select low.
  A chained access without direction change goes straight to rw,
  so it has no leading edge phase.
*/
module smc_state (
  input  logic     sys_clk4,
  input  logic     n_sys_reset4,
  smc_beat_if.fsm  bus,
  output logic     idle
);
  import smc_pkg::*;

  smc_state_e cur_q;
  smc_state_e beat_end_state;  // Where to go after the last beat cycle

  assign bus.cur_state = cur_q;
  assign idle = (bus.next_state == st_idle);  // Host may strobe

  // ------------------------------
  // Beat and access decodes
  // ------------------------------
  always_comb
  begin
    bus.beat_done = ((cur_q == st_rw) && (bus.r_ws_count == 8'd0) &&
                     (bus.r_cste_count == 2'd0)) ||
                    ((cur_q == st_float) && (bus.r_cste_count == 2'd0));
    // Accept in idle, or in the final cycle of the final beat
    bus.valid_access = bus.new_access &&
                       ((cur_q == st_idle) || (bus.beat_done && bus.mac_done));
    // Read window opens oete cycles before end of rw
    bus.latch_data = (cur_q == st_rw) && (bus.r_ws_count <= {6'd0, bus.oete_store});
  end

  // Successor of a finished beat
  always_comb
  begin
    if (!bus.mac_done)
    begin
      if (bus.csle_store != 2'd0)
        beat_end_state = st_le;  // Next beat, with leading edge
      else
        beat_end_state = st_rw;
    end
    else if (bus.new_access)
    begin
      if (bus.rw_change)
        beat_end_state = st_store;  // Reload timing, chip select lifts
      else
        beat_end_state = st_rw;  // Chain, chip select held
    end
    else
      beat_end_state = st_idle;
  end

  // ------------------------------
  // Next state
  // ------------------------------
  always_comb
  begin
    unique case (cur_q)
      st_idle:
        bus.next_state = bus.new_access ? st_store : st_idle;
      st_store:
        bus.next_state = (bus.r_csle_count != 2'd0) ? st_le : st_rw;
      st_le:
        bus.next_state = (bus.r_csle_count != 2'd0) ? st_le : st_rw;
      st_rw:
      begin
        if (bus.r_ws_count != 8'd0)
          bus.next_state = st_rw;  // Still waiting
        else if (bus.r_cste_count != 2'd0)
          bus.next_state = st_float;
        else
          bus.next_state = beat_end_state;
      end
      st_float:
        bus.next_state = (bus.r_cste_count != 2'd0) ? st_float : beat_end_state;
      default:
        bus.next_state = st_idle;
    endcase
  end

  // Counter enables
  always_comb
  begin
    bus.le_enable = (bus.next_state == st_le);  // Count on every le entry
    // Reload wait count on entry to rw, also rw to rw across beats
    bus.ws_enable = (bus.next_state == st_rw) && ((cur_q != st_rw) || bus.beat_done);
    bus.cste_enable = (bus.next_state == st_float);
  end

  always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      cur_q <= st_idle;
    else
      cur_q <= bus.next_state;
  end

endmodule

// File: design/smc_counters.sv
/*
  Timing down-counters. cfg is sampled when an access is accepted
  and may change freely between accesses.
*/
module smc_counters (
  input  logic              sys_clk4,
  input  logic              n_sys_reset4,
  input  smc_pkg::smc_cfg_t cfg,
  smc_beat_if.cnt           bus
);
  import smc_pkg::*;

  logic [7:0] ws_store;    // Reload value per beat
  logic [1:0] cste_store;

  // ------------------------------
  // Stored timing set
  // ------------------------------
  always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
    begin
      bus.csle_store <= 2'd0;
      ws_store       <= 8'd0;
      bus.oete_store <= 2'd0;
      cste_store     <= 2'd0;
    end
    else if (bus.valid_access)
    begin
      bus.csle_store <= cfg.csle;
      ws_store       <= cfg.ws;
      bus.oete_store <= cfg.oete;
      cste_store     <= cfg.cste;
    end
  end

  // Leading edge, reloaded per beat
  always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      bus.r_csle_count <= 2'd0;
    else if (bus.valid_access)
      bus.r_csle_count <= cfg.csle;
    else if (bus.beat_done)
      bus.r_csle_count <= bus.csle_store - {1'b0, bus.le_enable};  // Into le now
    else if (bus.le_enable)
      bus.r_csle_count <= bus.r_csle_count - 2'd1;
  end

  // Wait states
  always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      bus.r_ws_count <= 8'd0;
    else if (bus.valid_access)
      bus.r_ws_count <= cfg.ws;  // Chained access uses new value
    else if (bus.ws_enable)
      bus.r_ws_count <= ws_store;
    else if (bus.r_ws_count != 8'd0)
      bus.r_ws_count <= bus.r_ws_count - 8'd1;  // Only nonzero in rw
  end

  // Trailing edge, holds cste until float
  always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
      bus.r_cste_count <= 2'd0;
    else if (bus.valid_access)
      bus.r_cste_count <= cfg.cste;
    else if (bus.beat_done)
      bus.r_cste_count <= cste_store;
    else if (bus.cste_enable)
      bus.r_cste_count <= bus.r_cste_count - 2'd1;
  end

endmodule

// File: design/smc_mac.sv
/*
  Splits a host access into MEM_WIDTH beats, least significant first.
  Beat addresses increment by the memory width in bytes.
  Read data is zero-extended to the access size.
*/
module smc_mac #(parameter int MEM_WIDTH = 8) (
  input  logic                             sys_clk4,
  input  logic                             n_sys_reset4,
  input  logic                             req,
  input  logic                             write,
  input  smc_pkg::smc_size_e               size,
  input  logic [smc_pkg::SMC_ADDR_W-1:0]   addr,
  input  logic [smc_pkg::SMC_DATA_W-1:0]   wdata,
  output logic [smc_pkg::SMC_DATA_W-1:0]   rdata,
  output logic                             done,
  smc_beat_if.mac                          bus
);
  import smc_pkg::*;

  localparam int BEAT_BYTES = MEM_WIDTH / 8;
  localparam int BEATS_MAX  = SMC_DATA_W / MEM_WIDTH;

  logic                  act_write;   // Active direction
  smc_size_e             act_size;
  logic [SMC_ADDR_W-1:0] act_addr;    // Current beat address
  logic [SMC_DATA_W-1:0] act_wdata;   // Remaining write data
  logic [SMC_DATA_W-1:0] wdata_next;
  logic [1:0]            beat_idx;    // Current beat
  logic [1:0]            beat_last;
  logic                  lat_q;       // Beat data already taken
  logic                  next_beat;
  logic                  capture;
  logic [SMC_DATA_W-1:0] rd_q;        // Assembly register
  logic [SMC_DATA_W-1:0] rd_next;
  logic [SMC_DATA_W-1:0] rdata_q;     // Last completed read

  // Index of the final beat for a size
  function automatic logic [1:0] last_beat(smc_size_e s);
    int bytes;
    bytes = 1 << int'(s);
    if (bytes <= BEAT_BYTES)
      return 2'd0;
    return 2'(bytes / BEAT_BYTES - 1);
  endfunction

  function automatic logic [SMC_DATA_W-1:0] size_mask(smc_size_e s);
    unique case (s)
      size_byte: return SMC_DATA_W'(32'h0000_00ff);
      size_half: return SMC_DATA_W'(32'h0000_ffff);
      default:   return '1;
    endcase
  endfunction

  assign bus.new_access = req;  // Strobe accepted in its own cycle
  assign bus.mac_done   = (beat_idx == beat_last);
  assign bus.rw_change  = (write != act_write) ||
                          (addr[SMC_ADDR_W-1] != act_addr[SMC_ADDR_W-1]);
  assign next_beat      = bus.beat_done && !bus.mac_done;
  assign capture        = bus.latch_data && !lat_q && !act_write;
  assign done           = bus.beat_done && bus.mac_done;

  // ------------------------------
  // Beat values for next cycle
  // ------------------------------
  always_comb
  begin
    bus.beat_addr  = act_addr;
    wdata_next     = act_wdata;
    bus.beat_write = act_write;
    if (bus.valid_access)
    begin
      bus.beat_addr  = addr;
      wdata_next     = wdata;
      bus.beat_write = write;
    end
    else if (next_beat)
    begin
      bus.beat_addr = act_addr + SMC_ADDR_W'(BEAT_BYTES);
      wdata_next    = act_wdata >> MEM_WIDTH;  // Next slice to bottom
    end
    bus.beat_wdata = wdata_next[MEM_WIDTH-1:0];
  end

  // Read lane insert
  always_comb
  begin
    rd_next = rd_q;
    if (capture)
    begin
      for (int i = 0; i < BEATS_MAX; i++)
      begin
        if (beat_idx == 2'(i))
          rd_next[i*MEM_WIDTH +: MEM_WIDTH] = bus.mem_rdata;
      end
    end
  end

  // Valid in the done cycle, held until the next read done
  assign rdata = (done && !act_write) ? (rd_next & size_mask(act_size)) : rdata_q;

  always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
    begin
      act_write <= 1'b0;
      act_size  <= size_byte;
      beat_idx  <= 2'd0;
      beat_last <= 2'd0;  // mac_done high while idle
      lat_q     <= 1'b0;
    end
    else
    begin
      act_write <= bus.beat_write;
      if (bus.valid_access)
      begin
        act_size  <= size;
        beat_idx  <= 2'd0;
        beat_last <= last_beat(size);
      end
      else if (next_beat)
        beat_idx <= beat_idx + 2'd1;
      if (bus.beat_done)
        lat_q <= 1'b0;  // Rearm per beat
      else if (capture)
        lat_q <= 1'b1;
    end
  end

  // Payload
  always_ff @(posedge sys_clk4)
  begin
    act_addr  <= bus.beat_addr;
    act_wdata <= wdata_next;
    rd_q      <= rd_next;
    if (done && !act_write)
      rdata_q <= rdata;
  end

endmodule

// File: design/smc_strobes.sv
/*
  External SRAM pins, registered from the next state so that
  they line up with the state register. Strobes are active low.
*/
module smc_strobes #(parameter int MEM_WIDTH = 8) (
  input  logic                           sys_clk4,
  input  logic                           n_sys_reset4,
  smc_beat_if.pins                       bus,
  output logic [smc_pkg::SMC_ADDR_W-1:0] mem_addr,
  output logic [MEM_WIDTH-1:0]           mem_wdata,
  output logic                           mem_n_cs,
  output logic                           mem_n_oe,
  output logic                           mem_n_we
);
  import smc_pkg::*;

  logic cs_next;  // Chip select phase
  logic rw_next;  // Strobe phase

  assign cs_next = (bus.next_state == st_le) || (bus.next_state == st_rw) ||
                   (bus.next_state == st_float);
  assign rw_next = (bus.next_state == st_rw);

  // ------------------------------
  // Strobes
  // ------------------------------
  always_ff @(posedge sys_clk4 or negedge n_sys_reset4)
  begin
    if (!n_sys_reset4)
    begin
      mem_n_cs <= 1'b1;
      mem_n_oe <= 1'b1;
      mem_n_we <= 1'b1;
    end
    else
    begin
      mem_n_cs <= !cs_next;
      mem_n_we <= !(rw_next && bus.beat_write);
      // Rises after the first latch cycle; rearmed at beat end
      mem_n_oe <= !(rw_next && !bus.beat_write) || (bus.latch_data && !bus.beat_done);
    end
  end

  // Address and data follow the beat
  always_ff @(posedge sys_clk4)
  begin
    mem_addr  <= bus.beat_addr;
    mem_wdata <= bus.beat_wdata;
  end

endmodule

// File: design/smc_top.sv
/*
  Static memory controller top. MEM_WIDTH is 8, 16 or 32.
  req is a single-cycle strobe, legal only while idle or done is high.
*/
module smc_top #(parameter int MEM_WIDTH = 8) (
  input  logic                           sys_clk4,
  input  logic                           n_sys_reset4,
  // Host side
  input  logic                           req,
  input  logic                           write,
  input  smc_pkg::smc_size_e             size,
  input  logic [smc_pkg::SMC_ADDR_W-1:0] addr,
  input  logic [smc_pkg::SMC_DATA_W-1:0] wdata,
  input  logic [1:0]                     cfg_csle,
  input  logic [7:0]                     cfg_ws,
  input  logic [1:0]                     cfg_oete,
  input  logic [1:0]                     cfg_cste,
  output logic [smc_pkg::SMC_DATA_W-1:0] rdata,
  output logic                           done,
  output logic                           idle,
  // Memory side
  output logic [smc_pkg::SMC_ADDR_W-1:0] mem_addr,
  output logic [MEM_WIDTH-1:0]           mem_wdata,
  output logic                           mem_n_cs,
  output logic                           mem_n_oe,
  output logic                           mem_n_we,
  input  logic [MEM_WIDTH-1:0]           mem_rdata
);
  import smc_pkg::*;

  smc_cfg_t cfg;  // Packed timing set

  assign cfg = '{csle: cfg_csle, ws: cfg_ws, oete: cfg_oete, cste: cfg_cste};

  smc_beat_if #(.MEM_WIDTH(MEM_WIDTH)) bus (.mem_rdata(mem_rdata));

  smc_state u_state (
    .sys_clk4(sys_clk4), .n_sys_reset4(n_sys_reset4), .bus(bus.fsm), .idle(idle)
  );

  smc_counters u_counters (
    .sys_clk4(sys_clk4), .n_sys_reset4(n_sys_reset4), .cfg(cfg), .bus(bus.cnt)
  );

  smc_mac #(.MEM_WIDTH(MEM_WIDTH)) u_mac (
    .sys_clk4(sys_clk4), .n_sys_reset4(n_sys_reset4),
    .req(req), .write(write), .size(size), .addr(addr), .wdata(wdata),
    .rdata(rdata), .done(done), .bus(bus.mac)
  );

  smc_strobes #(.MEM_WIDTH(MEM_WIDTH)) u_strobes (
    .sys_clk4(sys_clk4), .n_sys_reset4(n_sys_reset4), .bus(bus.pins),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_n_cs(mem_n_cs), .mem_n_oe(mem_n_oe), .mem_n_we(mem_n_we)
  );

endmodule

// File: sim/smc_tb_sram.sv
/*
  Byte-wide SRAM model for the testbench, 256 locations.
  Address bits above 7 are ignored. Writes sample the pins on the clock edge.
  Keeps mem_n_we pulse widths, chip-select run lengths and the gaps between runs.
*/
module smc_tb_sram (
  input  logic        sys_clk4,
  input  logic [31:0] mem_addr,
  input  logic [7:0]  mem_wdata,
  input  logic        mem_n_cs,
  input  logic        mem_n_oe,
  input  logic        mem_n_we,
  output logic [7:0]  mem_rdata
);
  logic [7:0] mem [0:255];
  int we_run    = 0;     // Current mem_n_we low run
  int we_count  = 0;     // Finished write pulses
  int we_width [0:63];   // Ring of pulse widths
  int cs_run    = 0;
  int cs_count  = 0;     // Finished chip-select runs
  int cs_last   = 0;     // Latest run length
  int gap_run   = 0;
  int gap_last  = 0;     // High time before the latest run

  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = 8'(i * 29 + 17);  // Every address bit shows in the data
  end

  // Read path, only while selected and enabled
  assign mem_rdata = (!mem_n_cs && !mem_n_oe) ? mem[mem_addr[7:0]] : 8'h00;

  always @(posedge sys_clk4)
  begin
    if (!mem_n_cs && !mem_n_we)
      mem[mem_addr[7:0]] = mem_wdata;
  end

  // ------------------------------
  // Strobe monitor
  // ------------------------------
  always @(posedge sys_clk4)
  begin
    if (!mem_n_we)
      we_run <= we_run + 1;
    else if (we_run != 0)
    begin
      we_width[we_count % 64] <= we_run;  // Pulse just ended
      we_count <= we_count + 1;
      we_run   <= 0;
    end
    if (!mem_n_cs)
    begin
      cs_run <= cs_run + 1;
      if (gap_run != 0)
      begin
        gap_last  <= gap_run;
        gap_run   <= 0;
      end
    end
    else
    begin
      gap_run <= gap_run + 1;
      if (cs_run != 0)
      begin
        cs_last  <= cs_run;  // Run just ended
        cs_count <= cs_count + 1;
        cs_run   <= 0;
      end
    end
  end

endmodule

// File: sim/smc_tb.sv
/*
  Directed tests for smc_top with MEM_WIDTH 8 and a byte SRAM model.
  Requests are strobed only while idle or in the cycle of done.
  Outputs are sampled on the falling clock edge.
*/
module smc_tb;
  import smc_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int BEAT_WORST      = 16;  // csle 3, ws 9, cste 3
  localparam int TEST_BEATS      = 123;  // 1 + 4 + 12 * 8 + 8 + 8 + 6
  localparam int TEST_ACCESSES   = 35;   // 1 + 1 + 24 + 5 + 2 + 2
  localparam int ACCESS_OVERHEAD = 6;   // Strobe, store, settle, timing set
  localparam int WATCHDOG_CYCLES = 2 * (TEST_BEATS * BEAT_WORST +
                                        TEST_ACCESSES * ACCESS_OVERHEAD + 2);
  localparam int DONE_LIMIT      = 4 * BEAT_WORST + 4;  // One word access

  logic        sys_clk4;
  logic        n_sys_reset4;
  logic        req;
  logic        write;
  smc_size_e   size;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [1:0]  cfg_csle;
  logic [7:0]  cfg_ws;
  logic [1:0]  cfg_oete;
  logic [1:0]  cfg_cste;
  logic [31:0] rdata;
  logic        done;
  logic        idle;
  logic [31:0] mem_addr;
  logic [7:0]  mem_wdata;
  logic        mem_n_cs;
  logic        mem_n_oe;
  logic        mem_n_we;
  logic [7:0]  mem_rdata;

  int         errors = 0;
  int         checks = 0;
  logic [7:0] shadow [0:255];  // Expected SRAM contents

  smc_top #(.MEM_WIDTH(8)) DUT (
    .sys_clk4(sys_clk4), .n_sys_reset4(n_sys_reset4),
    .req(req), .write(write), .size(size), .addr(addr), .wdata(wdata),
    .cfg_csle(cfg_csle), .cfg_ws(cfg_ws), .cfg_oete(cfg_oete), .cfg_cste(cfg_cste),
    .rdata(rdata), .done(done), .idle(idle),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_n_cs(mem_n_cs),
    .mem_n_oe(mem_n_oe), .mem_n_we(mem_n_we), .mem_rdata(mem_rdata)
  );

  smc_tb_sram u_sram (
    .sys_clk4(sys_clk4), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
    .mem_n_cs(mem_n_cs), .mem_n_oe(mem_n_oe), .mem_n_we(mem_n_we),
    .mem_rdata(mem_rdata)
  );

  initial
  begin
    sys_clk4 = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk4 = !sys_clk4;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("checks %0d, errors %0d", checks, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic int nbytes(smc_size_e s);
    return 1 << int'(s);
  endfunction

  // Zero-extended read value from the shadow copy
  function automatic logic [31:0] expect_read(smc_size_e s, logic [31:0] a);
    logic [31:0] v;
    v = 32'h0;
    for (int i = 0; i < nbytes(s); i++)
      v[8*i +: 8] = shadow[8'(a + 32'(i))];
    return v;
  endfunction

  task automatic set_timing(logic [1:0] csle, logic [7:0] ws, logic [1:0] oete,
                            logic [1:0] cste);
    @(posedge sys_clk4);
    cfg_csle <= csle;
    cfg_ws   <= ws;
    cfg_oete <= oete;
    cfg_cste <= cste;
  endtask

  task automatic start_access(logic w, smc_size_e s, logic [31:0] a, logic [31:0] d);
    @(posedge sys_clk4);
    req   <= 1'b1;  // One-cycle strobe
    write <= w;
    size  <= s;
    addr  <= a;
    wdata <= d;
    @(posedge sys_clk4);
    req   <= 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    @(negedge sys_clk4);
    while (!done && n < DONE_LIMIT)
    begin
      n++;
      @(negedge sys_clk4);
    end
    if (!done)
    begin
      errors++;
      $display("done did not arrive within %0d cycles at %0t", DONE_LIMIT, $time);
    end
  endtask

  task automatic settle();
    repeat (2) @(negedge sys_clk4);  // Last write and monitor update land
  endtask

  // Written lanes match, the byte past the access is untouched
  task automatic check_write_bytes(smc_size_e s, logic [31:0] a, logic [31:0] d);
    logic [7:0] b;
    for (int i = 0; i < 5; i++)
    begin
      b = 8'(a + 32'(i));
      if (i < nbytes(s))
        shadow[b] = d[8*i +: 8];
      check_value($sformatf("mem[%02h]", b), 32'(u_sram.mem[b]), 32'(shadow[b]));
    end
  endtask

  task automatic write_check(smc_size_e s, logic [31:0] a, logic [31:0] d);
    start_access(1'b1, s, a, d);
    wait_done();
    settle();
    check_write_bytes(s, a, d);
  endtask

  task automatic read_check(smc_size_e s, logic [31:0] a);
    start_access(1'b0, s, a, 32'h0);
    wait_done();
    check_value("rdata", rdata, expect_read(s, a));  // Valid in done cycle
  endtask

  task automatic check_quiet();
    check_value("idle", 32'(idle), 32'd1);
    check_value("done", 32'(done), 32'd0);
    check_value("mem_n_cs", 32'(mem_n_cs), 32'd1);
    check_value("mem_n_oe", 32'(mem_n_oe), 32'd1);
    check_value("mem_n_we", 32'(mem_n_we), 32'd1);
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_idle();
    check_quiet();  // Straight out of reset
    set_timing(2'd0, 8'd0, 2'd0, 2'd0);
    read_check(size_byte, 32'h05);
    check_value("idle", 32'(idle), 32'd1);  // Nothing pending at done
    @(negedge sys_clk4);
    check_quiet();
  endtask

  task automatic test_word_read();
    set_timing(2'd1, 8'd2, 2'd1, 2'd1);
    read_check(size_word, 32'h10);  // Four bytes, LSB first
    settle();
  endtask

  task automatic test_write_readback();
    smc_size_e   s;
    logic [31:0] a;
    logic [31:0] d;
    for (int k = 0; k < 12; k++)
    begin
      s = smc_size_e'($urandom % 3);
      a = $urandom % 240;
      d = $urandom;
      set_timing(2'($urandom % 4), 8'($urandom % 4), 2'($urandom % 4), 2'($urandom % 4));
      write_check(s, a, d);
      read_check(s, a);
      settle();
    end
  endtask

  task automatic test_ws_width();
    int ws_list [4];
    int start;
    ws_list = '{0, 3, 6, 9};
    for (int k = 0; k < 4; k++)
    begin
      set_timing(2'd1, 8'(ws_list[k]), 2'd0, 2'd1);
      start = u_sram.we_count;
      write_check(size_byte, 32'h40 + 32'(k), $urandom);
      check_value("we pulses", 32'(u_sram.we_count - start), 32'd1);
      check_value("we width", 32'(u_sram.we_width[start % 64]), 32'(ws_list[k] + 1));
    end
    // Four beats, le cycle between them splits the pulses
    set_timing(2'd1, 8'd2, 2'd0, 2'd0);
    start = u_sram.we_count;
    write_check(size_word, 32'h60, $urandom);
    check_value("we pulses", 32'(u_sram.we_count - start), 32'd4);
    for (int j = 0; j < 4; j++)
      check_value($sformatf("we width %0d", j),
                  32'(u_sram.we_width[(start + j) % 64]), 32'd3);
  endtask

  task automatic test_chain();
    int runs;
    runs = u_sram.cs_count;
    set_timing(2'd1, 8'd1, 2'd0, 2'd1);  // Beat of 4 cycles
    start_access(1'b0, size_word, 32'h20, 32'h0);
    repeat (4 * 4) @(posedge sys_clk4);  // Up to the done cycle
    req  <= 1'b1;
    addr <= 32'h24;
    @(negedge sys_clk4);
    check_value("done", 32'(done), 32'd1);
    check_value("rdata", rdata, expect_read(size_word, 32'h20));
    @(posedge sys_clk4);
    req <= 1'b0;
    wait_done();
    check_value("rdata", rdata, expect_read(size_word, 32'h24));
    settle();
    check_value("cs runs", 32'(u_sram.cs_count - runs), 32'd1);
    // First beat of the chained access starts in rw
    check_value("cs run length", 32'(u_sram.cs_last), 32'(16 + 3 + 3 * 4));
  endtask

  task automatic test_dir_change();
    logic [31:0] d;
    d = $urandom;
    set_timing(2'd0, 8'd2, 2'd1, 2'd1);  // Beat of 4 cycles
    start_access(1'b0, size_half, 32'h80, 32'h0);
    repeat (2 * 4) @(posedge sys_clk4);
    req   <= 1'b1;
    write <= 1'b1;
    size  <= size_word;
    addr  <= 32'h84;
    wdata <= d;
    @(negedge sys_clk4);
    check_value("done", 32'(done), 32'd1);
    check_value("rdata", rdata, expect_read(size_half, 32'h80));
    @(posedge sys_clk4);
    req <= 1'b0;
    wait_done();
    settle();
    check_write_bytes(size_word, 32'h84, d);
    check_value("cs gap", 32'(u_sram.gap_last), 32'd1);  // Store only
  endtask

  initial
  begin
    void'($urandom(15));
    n_sys_reset4 = 1'b0;
    req      = 1'b0;
    write    = 1'b0;
    size     = size_byte;
    addr     = 32'h0;
    wdata    = 32'h0;
    cfg_csle = 2'd0;
    cfg_ws   = 8'd0;
    cfg_oete = 2'd0;
    cfg_cste = 2'd0;
    repeat (2) @(posedge sys_clk4);
    n_sys_reset4 <= 1'b1;
    @(negedge sys_clk4);
    for (int i = 0; i < 256; i++)
      shadow[i] = u_sram.mem[i];  // Start from the model fill
    test_idle();
    test_word_read();
    test_write_readback();
    test_ws_width();
    test_chain();
    test_dir_change();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// File: verilog.f
design/smc_pkg.sv
design/smc_beat_if.sv
design/smc_state.sv
design/smc_counters.sv
design/smc_mac.sv
design/smc_strobes.sv
design/smc_top.sv
sim/smc_tb_sram.sv
sim/smc_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= smc_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
